// File: hdl/memPkg.sv
package memPkg;

    // client side widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // ram side
    localparam int BYTE_W     = 8;
    localparam int RAM_ADDR_W = 12;
    localparam int RAM_DEPTH  = 1 << RAM_ADDR_W;

    // counts 0..N for a load, so one step past a full word
    localparam int CNT_W = 3;

    typedef enum logic [1:0] {
        LEN1    = 2'd0,
        LEN2    = 2'd1,
        LEN4    = 2'd2,
        LEN_RSV = 2'd3
    } accessLen_t;

    // byte count of an access
    function automatic logic [CNT_W-1:0] lenBytes(accessLen_t len);
        logic [CNT_W-1:0] n;
        case (len)
            LEN1: begin
                n = CNT_W'(1);
            end
            LEN2: begin
                n = CNT_W'(2);
            end
            LEN4: begin
                n = CNT_W'(4);
            end
            default: begin
                // reserved code, treated as a full word
                n = CNT_W'(4);
            end
        endcase
        return n;
    endfunction

endpackage

// File: hdl/byteRam.sv
`timescale 1ns/1ps

module byteRam
    import memPkg::*;
(
    input  logic                  clk,
    input  logic                  i_we,
    input  logic [RAM_ADDR_W-1:0] i_addr,
    input  logic [BYTE_W-1:0]     i_wdata,
    input  logic                  i_hold,
    output logic [BYTE_W-1:0]     o_rdata
);

    logic [BYTE_W-1:0] mem [RAM_DEPTH];

    // contents start cleared
    initial begin
        for (int i = 0; i < RAM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // registered read, frozen with the rest of the subsystem
    always_ff @(posedge clk) begin
        if (!i_hold) begin
            o_rdata <= mem[i_addr];
        end
    end

endmodule

// File: hdl/memArbiter.sv
`timescale 1ns/1ps

module memArbiter
    import memPkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic              i_fetchValid,
    input  logic [ADDR_W-1:0] i_fetchAddr,
    output logic              o_fetchReady,

    input  logic              i_dataValid,
    input  logic              i_dataStore,
    input  accessLen_t        i_dataLen,
    input  logic [ADDR_W-1:0] i_dataAddr,
    input  logic [DATA_W-1:0] i_dataWdata,
    output logic              o_dataReady,

    output logic              o_reqValid,
    output logic              o_reqStore,
    output accessLen_t        o_reqLen,
    output logic [ADDR_W-1:0] o_reqAddr,
    output logic [DATA_W-1:0] o_reqWdata,
    input  logic              i_reqReady,

    input  logic              i_respValid,
    input  logic [DATA_W-1:0] i_respRdata,

    output logic              o_fetchRespValid,
    output logic [DATA_W-1:0] o_fetchInst,
    output logic              o_dataRespValid,
    output logic [DATA_W-1:0] o_dataRdata
);

    logic ownerData;
    logic accept;

    // data port has priority
    assign o_reqValid = i_dataValid || i_fetchValid;
    assign o_reqStore = i_dataValid ? i_dataStore : 1'b0;
    assign o_reqLen   = i_dataValid ? i_dataLen : LEN4;
    assign o_reqAddr  = i_dataValid ? i_dataAddr : i_fetchAddr;
    assign o_reqWdata = i_dataValid ? i_dataWdata : '0;

    assign o_dataReady  = i_reqReady;
    assign o_fetchReady = i_reqReady && !i_dataValid;

    assign accept = o_reqValid && i_reqReady;

    // owner of the transaction in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            ownerData <= 1'b0;
        end else if (accept) begin
            ownerData <= i_dataValid;
        end
    end

    assign o_fetchRespValid = i_respValid && !ownerData;
    assign o_dataRespValid  = i_respValid && ownerData;

    assign o_fetchInst = ownerData ? '0 : i_respRdata;
    assign o_dataRdata = ownerData ? i_respRdata : '0;

endmodule

// File: hdl/memSequencer.sv
`timescale 1ns/1ps

module memSequencer
    import memPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_hold,

    input  logic                  i_reqValid,
    input  logic                  i_reqStore,
    input  accessLen_t            i_reqLen,
    input  logic [ADDR_W-1:0]     i_reqAddr,
    input  logic [DATA_W-1:0]     i_reqWdata,
    output logic                  o_reqReady,

    output logic                  o_respValid,
    output logic [DATA_W-1:0]     o_respRdata,

    output logic                  o_ramWe,
    output logic [RAM_ADDR_W-1:0] o_ramAddr,
    output logic [BYTE_W-1:0]     o_ramWdata,
    input  logic [BYTE_W-1:0]     i_ramRdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_STORE,
        ST_RESP
    } seqState_t;

    seqState_t             state;
    logic [CNT_W-1:0]      cnt;
    logic [CNT_W-1:0]      numBytes;
    logic [1:0]            capIdx;
    logic                  accept;

    logic                  storeQ;
    accessLen_t            lenQ;
    logic [RAM_ADDR_W-1:0] addrQ;
    logic [DATA_W-1:0]     wdataQ;
    logic [DATA_W-1:0]     asmQ;
    logic [DATA_W-1:0]     lenMask;

    assign numBytes = lenBytes(lenQ);
    assign accept   = i_reqValid && o_reqReady;

    // ram output lags the address by one cycle
    assign capIdx = 2'(cnt - 1'b1);

    assign o_reqReady = (state == ST_IDLE) && !i_hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else if (!i_hold) begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= i_reqStore ? ST_STORE : ST_LOAD;
                        cnt   <= '0;
                    end
                end
                ST_LOAD: begin
                    // one extra step to collect the last byte
                    cnt <= cnt + 1'b1;
                    if (cnt == numBytes) begin
                        state <= ST_RESP;
                    end
                end
                ST_STORE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == numBytes - 1'b1) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // request fields and load assembly
    always_ff @(posedge clk) begin
        if (!i_hold) begin
            if (accept) begin
                storeQ <= i_reqStore;
                lenQ   <= i_reqLen;
                addrQ  <= i_reqAddr[RAM_ADDR_W-1:0];
                wdataQ <= i_reqWdata;
            end else if (state == ST_LOAD && cnt != '0) begin
                // little endian so byte k lands in lane k
                asmQ[capIdx*BYTE_W +: BYTE_W] <= i_ramRdata;
            end
        end
    end

    // address wraps at the top of ram
    assign o_ramAddr  = addrQ + RAM_ADDR_W'(cnt);
    assign o_ramWdata = wdataQ[cnt[1:0]*BYTE_W +: BYTE_W];
    assign o_ramWe    = (state == ST_STORE) && !i_hold;

    // upper lanes may still hold bytes of an earlier load
    always_comb begin
        case (lenQ)
            LEN1: begin
                lenMask = DATA_W'({BYTE_W{1'b1}});
            end
            LEN2: begin
                lenMask = DATA_W'({(2*BYTE_W){1'b1}});
            end
            default: begin
                lenMask = '1;
            end
        endcase
    end

    // pulse waits out a hold
    assign o_respValid = (state == ST_RESP) && !i_hold;
    assign o_respRdata = storeQ ? '0 : (asmQ & lenMask);

endmodule

// File: hdl/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem
    import memPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_ioBufferFull,

    input  logic              i_fetchValid,
    input  logic [ADDR_W-1:0] i_fetchAddr,
    output logic              o_fetchReady,
    output logic              o_fetchRespValid,
    output logic [DATA_W-1:0] o_fetchInst,

    input  logic              i_dataValid,
    input  logic              i_dataStore,
    input  accessLen_t        i_dataLen,
    input  logic [ADDR_W-1:0] i_dataAddr,
    input  logic [DATA_W-1:0] i_dataWdata,
    output logic              o_dataReady,
    output logic              o_dataRespValid,
    output logic [DATA_W-1:0] o_dataRdata
);

    logic                  reqValid;
    logic                  reqStore;
    accessLen_t            reqLen;
    logic [ADDR_W-1:0]     reqAddr;
    logic [DATA_W-1:0]     reqWdata;
    logic                  reqReady;
    logic                  respValid;
    logic [DATA_W-1:0]     respRdata;

    logic                  ramWe;
    logic [RAM_ADDR_W-1:0] ramAddr;
    logic [BYTE_W-1:0]     ramWdata;
    logic [BYTE_W-1:0]     ramRdata;

    memArbiter arbiter (
        .clk              (clk),
        .rst              (rst),
        .i_fetchValid     (i_fetchValid),
        .i_fetchAddr      (i_fetchAddr),
        .o_fetchReady     (o_fetchReady),
        .i_dataValid      (i_dataValid),
        .i_dataStore      (i_dataStore),
        .i_dataLen        (i_dataLen),
        .i_dataAddr       (i_dataAddr),
        .i_dataWdata      (i_dataWdata),
        .o_dataReady      (o_dataReady),
        .o_reqValid       (reqValid),
        .o_reqStore       (reqStore),
        .o_reqLen         (reqLen),
        .o_reqAddr        (reqAddr),
        .o_reqWdata       (reqWdata),
        .i_reqReady       (reqReady),
        .i_respValid      (respValid),
        .i_respRdata      (respRdata),
        .o_fetchRespValid (o_fetchRespValid),
        .o_fetchInst      (o_fetchInst),
        .o_dataRespValid  (o_dataRespValid),
        .o_dataRdata      (o_dataRdata)
    );

    memSequencer sequencer (
        .clk         (clk),
        .rst         (rst),
        .i_hold      (i_ioBufferFull),
        .i_reqValid  (reqValid),
        .i_reqStore  (reqStore),
        .i_reqLen    (reqLen),
        .i_reqAddr   (reqAddr),
        .i_reqWdata  (reqWdata),
        .o_reqReady  (reqReady),
        .o_respValid (respValid),
        .o_respRdata (respRdata),
        .o_ramWe     (ramWe),
        .o_ramAddr   (ramAddr),
        .o_ramWdata  (ramWdata),
        .i_ramRdata  (ramRdata)
    );

    byteRam ram (
        .clk     (clk),
        .i_we    (ramWe),
        .i_addr  (ramAddr),
        .i_wdata (ramWdata),
        .i_hold  (i_ioBufferFull),
        .o_rdata (ramRdata)
    );

endmodule

// File: verification/memSequencer_props.sv
`timescale 1ns/1ps

module memSequencerProps
    import memPkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       i_hold,
    input logic       i_reqValid,
    input accessLen_t i_reqLen,
    input logic       o_reqReady,
    input logic       o_respValid,
    input logic       o_ramWe
);

    logic busy;
    logic accept;

    assign accept = i_reqValid && o_reqReady;

    // tracks a transaction from acceptance to its response
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (!i_hold) begin
            if (accept) begin
                busy <= 1'b1;
            end else if (o_respValid) begin
                busy <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) busy |-> !o_reqReady)
        else $error("ready high while a transaction is in progress");

    assert property (@(posedge clk) disable iff (rst) o_respValid |=> !o_respValid)
        else $error("response valid high on two cycles in a row");

    assert property (@(posedge clk) disable iff (rst) i_hold |-> !o_ramWe)
        else $error("ram write during hold");

    assert property (@(posedge clk) disable iff (rst) accept |-> i_reqLen != LEN_RSV)
        else $error("accepted request with reserved length");

endmodule

bind memSequencer memSequencerProps props (
    .clk         (clk),
    .rst         (rst),
    .i_hold      (i_hold),
    .i_reqValid  (i_reqValid),
    .i_reqLen    (i_reqLen),
    .o_reqReady  (o_reqReady),
    .o_respValid (o_respValid),
    .o_ramWe     (o_ramWe)
);

// File: verification/memSubsystemTb.sv
`timescale 1ns/1ps

module memSubsystemTb
    import memPkg::*;
();

    localparam logic [31:0] SEED = 32'h7168_cfbf;
    // transactions times the 4-byte load latency, plus hold cycles, doubled
    localparam int TRANSACTIONS = 59;
    localparam int HOLD_CYCLES  = 9;
    localparam int CYCLE_LIMIT  = (TRANSACTIONS * 5 + HOLD_CYCLES) * 2;
    localparam int WAIT_LIMIT   = 16;

    logic              clk;
    logic              rst;
    logic              i_ioBufferFull;
    logic              i_fetchValid;
    logic [ADDR_W-1:0] i_fetchAddr;
    logic              o_fetchReady;
    logic              o_fetchRespValid;
    logic [DATA_W-1:0] o_fetchInst;
    logic              i_dataValid;
    logic              i_dataStore;
    accessLen_t        i_dataLen;
    logic [ADDR_W-1:0] i_dataAddr;
    logic [DATA_W-1:0] i_dataWdata;
    logic              o_dataReady;
    logic              o_dataRespValid;
    logic [DATA_W-1:0] o_dataRdata;

    logic [BYTE_W-1:0] model [RAM_DEPTH];
    logic [31:0]       lcgState;
    int                cycleCount;

    memSubsystem dut (
        .clk              (clk),
        .rst              (rst),
        .i_ioBufferFull   (i_ioBufferFull),
        .i_fetchValid     (i_fetchValid),
        .i_fetchAddr      (i_fetchAddr),
        .o_fetchReady     (o_fetchReady),
        .o_fetchRespValid (o_fetchRespValid),
        .o_fetchInst      (o_fetchInst),
        .i_dataValid      (i_dataValid),
        .i_dataStore      (i_dataStore),
        .i_dataLen        (i_dataLen),
        .i_dataAddr       (i_dataAddr),
        .i_dataWdata      (i_dataWdata),
        .o_dataReady      (o_dataReady),
        .o_dataRespValid  (o_dataRespValid),
        .o_dataRdata      (o_dataRdata)
    );

    always #20 clk = ~clk;

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            reportFailure($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int byteCount(input accessLen_t len);
        case (len)
            LEN1: return 1;
            LEN2: return 2;
            default: return 4;
        endcase
    endfunction

    // little endian, zero extended, wraps at the top of ram
    function automatic logic [DATA_W-1:0] modelLoad(input logic [ADDR_W-1:0] addr,
                                                    input accessLen_t len);
        logic [DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < byteCount(len); i++) begin
            v[i*BYTE_W +: BYTE_W] = model[(addr + i) % RAM_DEPTH];
        end
        return v;
    endfunction

    task automatic modelStore(input logic [ADDR_W-1:0] addr, input accessLen_t len,
                              input logic [DATA_W-1:0] wdata);
        for (int i = 0; i < byteCount(len); i++) begin
            model[(addr + i) % RAM_DEPTH] = wdata[i*BYTE_W +: BYTE_W];
        end
    endtask

    task automatic checkWord(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            reportFailure($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkLatency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            reportFailure($sformatf("mismatch %s latency expected %0d actual %0d",
                                    name, expected, actual));
        end
    endtask

    // returns right after the accepting edge
    task automatic waitAccept(input logic isData, input string name);
        int n;
        n = 0;
        forever begin
            @(negedge clk);
            if (isData && i_fetchValid && o_fetchReady) begin
                reportFailure($sformatf("%s: fetch port ready while data requests", name));
            end
            if (isData ? o_dataReady : o_fetchReady) begin
                break;
            end
            n++;
            if (n > WAIT_LIMIT) begin
                reportFailure($sformatf("%s: request was never accepted", name));
            end
        end
        @(posedge clk);
    endtask

    // counts cycles after acceptance and raises the buffer-full hold on request
    task automatic waitResp(input logic isData, input string name, input int holdStart,
                            input int holdCycles, output logic [DATA_W-1:0] data,
                            output int lat);
        logic done;
        done = 1'b0;
        lat = 0;
        while (!done) begin
            @(negedge clk);
            if (isData ? o_fetchRespValid : o_dataRespValid) begin
                reportFailure($sformatf("%s: response appeared on the wrong port", name));
            end
            if (o_dataReady || o_fetchReady) begin
                reportFailure($sformatf("%s: ready high during a transaction", name));
            end
            if (isData ? o_dataRespValid : o_fetchRespValid) begin
                data = isData ? o_dataRdata : o_fetchInst;
                done = 1'b1;
            end else if (lat > WAIT_LIMIT) begin
                reportFailure($sformatf("%s: no response arrived", name));
            end else begin
                @(posedge clk);
                lat++;
                i_ioBufferFull <= (lat >= holdStart) && (lat < holdStart + holdCycles);
            end
        end
    endtask

    task automatic dataAccess(input string name, input logic store, input accessLen_t len,
                              input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                              input int holdStart, input int holdCycles);
        logic [DATA_W-1:0] got;
        int lat;
        @(posedge clk);
        i_dataValid <= 1'b1;
        i_dataStore <= store;
        i_dataLen   <= len;
        i_dataAddr  <= addr;
        i_dataWdata <= wdata;
        waitAccept(1'b1, name);
        i_dataValid <= 1'b0;
        waitResp(1'b1, name, holdStart, holdCycles, got, lat);
        if (store) begin
            modelStore(addr, len, wdata);
            checkWord(name, '0, got);
            checkLatency(name, byteCount(len) + holdCycles, lat);
        end else begin
            checkWord(name, modelLoad(addr, len), got);
            checkLatency(name, byteCount(len) + 1 + holdCycles, lat);
        end
    endtask

    task automatic fetchAccess(input string name, input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] got;
        int lat;
        @(posedge clk);
        i_fetchValid <= 1'b1;
        i_fetchAddr  <= addr;
        waitAccept(1'b0, name);
        i_fetchValid <= 1'b0;
        waitResp(1'b0, name, 0, 0, got, lat);
        checkWord(name, modelLoad(addr, LEN4), got);
        checkLatency(name, 5, lat);
    endtask

    task automatic resetTest();
        @(negedge clk);
        if (!o_dataReady || !o_fetchReady) begin
            reportFailure("reset: a ready is low after reset");
        end
        if (o_dataRespValid || o_fetchRespValid) begin
            reportFailure("reset: a response valid is high after reset");
        end
    endtask

    task automatic roundTrip(input string name, input accessLen_t len,
                             input logic [ADDR_W-1:0] addr);
        dataAccess({name, " store"}, 1'b1, len, addr, nextRand(), 0, 0);
        dataAccess({name, " load"}, 1'b0, len, addr, '0, 0, 0);
    endtask

    task automatic contentionTest();
        logic [DATA_W-1:0] got;
        logic [DATA_W-1:0] wdata;
        int lat;
        wdata = nextRand();
        @(posedge clk);
        i_fetchValid <= 1'b1;
        i_fetchAddr  <= 32'h0000_0400;
        i_dataValid  <= 1'b1;
        i_dataStore  <= 1'b1;
        i_dataLen    <= LEN4;
        i_dataAddr   <= 32'h0000_0400;
        i_dataWdata  <= wdata;
        waitAccept(1'b1, "contention data");
        i_dataValid <= 1'b0;
        waitResp(1'b1, "contention data", 0, 0, got, lat);
        modelStore(32'h0000_0400, LEN4, wdata);
        checkWord("contention data", '0, got);
        checkLatency("contention data", 4, lat);
        // the fetch sees the data just stored
        waitAccept(1'b0, "contention fetch");
        i_fetchValid <= 1'b0;
        waitResp(1'b0, "contention fetch", 0, 0, got, lat);
        checkWord("contention fetch", modelLoad(32'h0000_0400, LEN4), got);
        checkLatency("contention fetch", 5, lat);
    endtask

    task automatic randomTest();
        logic [31:0]       op;
        accessLen_t        len;
        logic [ADDR_W-1:0] addr;
        string             name;
        for (int i = 0; i < 40; i++) begin
            name = $sformatf("random %0d", i);
            op = nextRand() % 3;
            case (nextRand() % 3)
                0: len = LEN1;
                1: len = LEN2;
                default: len = LEN4;
            endcase
            // small window around address zero, aliased through the upper bits
            addr = (nextRand() & 32'h0000_f03f) - 32'd32;
            if (op == 0) begin
                fetchAccess(name, addr);
            end else begin
                dataAccess(name, op == 2, len, addr, nextRand(), 0, 0);
            end
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        i_ioBufferFull = 1'b0;
        i_fetchValid   = 1'b0;
        i_fetchAddr    = '0;
        i_dataValid    = 1'b0;
        i_dataStore    = 1'b0;
        i_dataLen      = LEN1;
        i_dataAddr     = '0;
        i_dataWdata    = '0;
        cycleCount     = 0;
        lcgState       = SEED;
        for (int i = 0; i < RAM_DEPTH; i++) begin
            model[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        resetTest();
        roundTrip("len1 unaligned", LEN1, 32'h0000_0101);
        roundTrip("len1 top", LEN1, 32'h0000_0fff);
        roundTrip("len2 unaligned", LEN2, 32'h0000_0203);
        roundTrip("len2 wrap", LEN2, 32'h0000_1fff);
        roundTrip("len4 unaligned", LEN4, 32'h0000_0306);
        roundTrip("len4 wrap", LEN4, 32'h0000_0ffe);
        fetchAccess("fetch wrap", 32'h0000_2ffe);
        fetchAccess("fetch unaligned", 32'h0000_0307);
        contentionTest();
        dataAccess("hold store", 1'b1, LEN4, 32'h0000_0523, nextRand(), 2, 3);
        dataAccess("hold load", 1'b0, LEN2, 32'h0000_0524, '0, 1, 4);
        // hold lands on the response cycle itself
        dataAccess("hold response", 1'b0, LEN4, 32'h0000_0523, '0, 5, 2);
        randomTest();

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: memSubsystem.f
hdl/memPkg.sv
hdl/byteRam.sv
hdl/memArbiter.sv
hdl/memSequencer.sv
hdl/memSubsystem.sv
verification/memSequencer_props.sv
verification/memSubsystemTb.sv

// File: Bender.yml
package:
  name: memSubsystem

sources:
  - hdl/memPkg.sv
  - hdl/byteRam.sv
  - hdl/memArbiter.sv
  - hdl/memSequencer.sv
  - hdl/memSubsystem.sv

  - target: test
    files:
      - verification/memSequencer_props.sv
      - verification/memSubsystemTb.sv
